//--- Bender.yml
package:
  name: io_subsystem

sources:
  - verilog/busPkg.sv
  - verilog/ioMapPkg.sv
  - verilog/memOrIo.sv
  - verilog/dataMem.sv
  - verilog/btnDebounce.sv
  - verilog/displayPort.sv
  - verilog/ioSubsystem.sv
  - target: test
    files:
      - tb/ioSubsystemTb.sv

//--- list.f
verilog/busPkg.sv
verilog/ioMapPkg.sv
verilog/memOrIo.sv
verilog/dataMem.sv
verilog/btnDebounce.sv
verilog/displayPort.sv
verilog/ioSubsystem.sv
tb/ioSubsystemTb.sv

//--- tb/ioSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module ioSubsystemTb;
    import busPkg::*;
    import ioMapPkg::*;

    localparam int ResetCycles = 10;
    localparam int ScanTimeout = 200;                   // Cycles to see all eight digits
    localparam int MixOps      = 200;
    localparam int MixWords    = 32;                    // Small index set, forces overwrites

    logic       clk;
    logic       rstN;
    memAccess_t access;
    ioInputs_t  ioIn;
    word_t      rWdata;
    led_t       led;
    segOut_t    seg;

    ioInputs_t  drvIn;                                  // Applied with the next access

    // Reference model state
    word_t      modelMem [MemWords];
    bit         modelWritten [MemWords];
    led_t       expLed;
    word_t      expSeg;
    logic       expBtn;

    int         errorCount;
    int         timeoutCount;

    ioSubsystem ioSubsystem_inst (
        .clk    (clk),
        .rstN   (rstN),
        .access (access),
        .ioIn   (ioIn),
        .rWdata (rWdata),
        .led    (led),
        .seg    (seg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit isIoAddr(input word_t addr);
        return addr[31:8] == 24'hFFFFFC;
    endfunction

    // Lit segments {g..a}, inverted for the active low cathodes, dot dark
    function automatic logic [7:0] segPattern(input logic [3:0] value);
        logic [6:0] lit;
        case (value)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

    // Random upper bits, kept out of the IO window
    function automatic word_t randMemAddr(input int idx);
        word_t upper;
        word_t addr;
        upper = $urandom();
        addr = {upper[31:12], idx[9:0], 2'b00};
        if (isIoAddr(addr))
            addr[31] = 1'b0;
        return addr;
    endfunction

    function automatic word_t expectedLoad(input word_t addr);
        word_t value;
        if (addr == SwitchAddr)
            value = {20'b0, drvIn.switches};
        else if (addr == KeyAddr)
            value = drvIn.key;
        else if (addr == BtnAddr)
            value = {31'b0, expBtn};
        else
            value = modelMem[addr[11:2]];                // Every other load hits memory
        return value;
    endfunction

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkLed(input led_t got, input led_t exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkSeg(input segOut_t got, input segOut_t exp, input string what);
        if (got !== exp) begin
            errorCount++;
            $display("[FAIL] %0t: %s, got anode %b cathode %h expected anode %b cathode %h",
                     $time, what, got.anode, got.cathode, exp.anode, exp.cathode);
        end
    endtask

    // Drive just after the edge, return at the falling edge for sampling
    task automatic doAccess(input memAccess_t acc);
        @(posedge clk);
        #1;
        access = acc;
        ioIn   = drvIn;
        @(negedge clk);
    endtask

    task automatic idleCycles(input int cycles);
        memAccess_t acc;
        repeat (cycles) begin
            acc.addr  = $urandom();
            acc.read  = 1'b0;
            acc.write = 1'b0;
            acc.wdata = $urandom();
            doAccess(acc);
            checkWord(rWdata, acc.addr, "idle address passthrough");
            checkLed(led, expLed, "LED hold");
        end
    endtask

    task automatic storeWord(input word_t addr, input word_t data);
        memAccess_t acc;
        acc.addr  = addr;
        acc.read  = 1'b0;
        acc.write = 1'b1;
        acc.wdata = data;
        doAccess(acc);
        checkWord(rWdata, addr, "store address passthrough");
        checkLed(led, expLed, "LED before store lands");
        if (!isIoAddr(addr)) begin
            modelMem[addr[11:2]]     = data;
            modelWritten[addr[11:2]] = 1'b1;
        end
        if (addr == LedAddr)
            expLed = data[15:0];
        if (addr == SegAddr)
            expSeg = data;
    endtask

    task automatic loadWord(input word_t addr, input string what);
        memAccess_t acc;
        acc.addr  = addr;
        acc.read  = 1'b1;
        acc.write = 1'b0;
        acc.wdata = $urandom();
        doAccess(acc);
        checkWord(rWdata, expectedLoad(addr), what);
    endtask

    task automatic holdButton(input logic level, input int cycles);
        drvIn.btnRaw = level;
        idleCycles(cycles);
    endtask

    // Poll the scan until every digit has shown its nibble
    task automatic scanDisplay();
        logic [7:0] seen;
        segOut_t    exp;
        int         polls;
        int         lowCount;
        int         digit;
        seen  = '0;
        polls = 0;
        while (seen != 8'hFF && polls < ScanTimeout) begin
            idleCycles(1);
            polls++;
            lowCount = 0;
            digit    = 0;
            for (int i = 0; i < 8; i++) begin
                if (seg.anode[i] == 1'b0) begin
                    lowCount++;
                    digit = i;
                end
            end
            if (lowCount != 1) begin
                errorCount++;
                $display("[FAIL] %0t: anode %b does not select one digit", $time, seg.anode);
            end else begin
                exp.anode   = ~(8'b1 << digit);
                exp.cathode = segPattern(expSeg[4*digit +: 4]);
                checkSeg(seg, exp, "display digit");
                seen[digit] = 1'b1;
            end
        end
        if (seen != 8'hFF) begin
            timeoutCount++;
            $display("Timeout: the display scan did not show all eight digits in %0d cycles",
                     ScanTimeout);
        end
    endtask

    initial begin
        int idx;
        int pulseLen;
        void'($urandom(32'hf6d4_7730));
        errorCount   = 0;
        timeoutCount = 0;
        expLed       = '0;
        expSeg       = '0;
        expBtn       = 1'b0;
        foreach (modelWritten[i])
            modelWritten[i] = 1'b0;
        rstN   = 1'b0;
        access = '0;
        drvIn  = '0;
        ioIn   = '0;

        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkLed(led, '0, "LED after reset");
        checkSeg(seg, {8'hFE, segPattern(4'h0)}, "display after reset");

        // Fill the working set, then mix stores, loads and idles
        for (int i = 0; i < MixWords; i++)
            storeWord(randMemAddr(i), $urandom());
        for (int n = 0; n < MixOps; n++) begin
            idx = $urandom_range(0, MixWords - 1);
            case ($urandom_range(0, 3))
                0, 1: storeWord(randMemAddr(idx), $urandom());
                2: begin
                    if (modelWritten[idx])
                        loadWord(randMemAddr(idx), "memory load");
                    else
                        storeWord(randMemAddr(idx), $urandom());
                end
                default: idleCycles(1);
            endcase
        end

        // Switches and key
        for (int n = 0; n < 20; n++) begin
            drvIn.switches = switch_t'($urandom());
            drvIn.key      = $urandom();
            loadWord(SwitchAddr, "switch load");
            loadWord(KeyAddr, "key load");
            idleCycles(1);
        end

        // LED register, a display store must not touch it
        for (int n = 0; n < 10; n++) begin
            storeWord(LedAddr, $urandom());
            idleCycles(1);
            storeWord(SegAddr, $urandom());
            idleCycles(1);
        end

        for (int n = 0; n < 2; n++) begin
            storeWord(SegAddr, $urandom());
            scanDisplay();
        end

        // IO stores alias indices 792 and 793 but must leave memory alone
        storeWord(32'h0000_0C60, $urandom());
        storeWord(32'h0000_0C64, $urandom());
        storeWord(LedAddr, $urandom());
        storeWord(SegAddr, $urandom());
        idleCycles(1);
        loadWord(32'h0000_0C60, "memory below LED index after IO store");
        loadWord(32'h0000_0C64, "memory below display index after IO store");
        loadWord(LedAddr, "load at LED address reads memory");

        // Debounce, a full hold changes the level and a short pulse does not
        for (int n = 0; n < 4; n++) begin
            holdButton(!expBtn, DebounceCycles + 3);
            expBtn = !expBtn;
            loadWord(BtnAddr, "debounced button level");
            pulseLen = $urandom_range(1, DebounceCycles - 3);
            holdButton(!expBtn, pulseLen);
            holdButton(expBtn, 2);                      // Pulse still in the synchronizer
            loadWord(BtnAddr, "button level right after short pulse");
            holdButton(expBtn, DebounceCycles + 3);
            loadWord(BtnAddr, "button level after short pulse");
        end

        $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/btnDebounce.sv
`timescale 1ns/1ps
`default_nettype none

module btnDebounce (
    input  wire  clk,
    input  wire  rstN,
    input  wire  btnRaw,
    output logic btnLevel
);
    import ioMapPkg::*;

    logic    btnMeta;
    logic    btnSync;
    debCnt_t stableCnt;                             // Cycles the input has differed

    // Two stage synchronizer
    always_ff @(posedge clk) begin
        if (!rstN) begin
            btnMeta <= 1'b0;
            btnSync <= 1'b0;
        end else begin
            btnMeta <= btnRaw;
            btnSync <= btnMeta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stableCnt <= '0;
            btnLevel  <= 1'b0;
        end else if (btnSync == btnLevel) begin
            stableCnt <= '0;                        // Bounce back, start over
        end else if (stableCnt == DebounceLimit) begin
            btnLevel  <= btnSync;                   // Stable long enough
            stableCnt <= '0;
        end else begin
            stableCnt <= stableCnt + 1'b1;
        end
    end

    // Both ends of the window must have seen the input differ from the level
    levelNeedsWindow: assert property (
        @(posedge clk) disable iff (!rstN)
        $changed(btnLevel) |-> $past(btnSync != btnLevel) &&
                               $past(btnSync != btnLevel, DebounceCycles)
    ) else $error("btnDebounce: btnLevel changed before the debounce window");

endmodule

`default_nettype wire

//--- verilog/busPkg.sv
`default_nettype none

package busPkg;

    typedef logic [31:0] word_t;                    // Data word or byte address

    // Data memory sizing
    localparam int MemWords     = 1024;
    localparam int MemIndexBits = $clog2(MemWords);
    localparam int MemIndexLsb  = 2;                // Word aligned, byte bits dropped

    typedef logic [MemIndexBits-1:0] memIndex_t;    // Word index into data memory

    // One load/store request from the CPU, valid for a single cycle
    typedef struct packed {
        word_t addr;                                // ALU result
        logic  read;                                // Load strobe
        logic  write;                               // Store strobe
        word_t wdata;                               // Register value to store
    } memAccess_t;

endpackage

`default_nettype wire

//--- verilog/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem (
    input  wire                    clk,
    input  wire                    rstN,
    input  wire                    we,
    input  wire busPkg::memIndex_t index,
    input  wire busPkg::word_t     wdata,
    output busPkg::word_t          rdata
);
    import busPkg::*;

    word_t mem [MemWords];                          // Contents undefined until stored

    // Read is asynchronous so a load completes in its own cycle
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // An unknown enable would corrupt an arbitrary word
    weKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(we))
        else $error("dataMem: write enable unknown");

endmodule

`default_nettype wire

//--- verilog/displayPort.sv
`timescale 1ns/1ps
`default_nettype none

module displayPort (
    input  wire                clk,
    input  wire                rstN,
    input  wire                ledWe,
    input  wire                segWe,
    input  wire busPkg::word_t storeData,
    output ioMapPkg::led_t     led,
    output ioMapPkg::segOut_t  seg
);
    import busPkg::*;
    import ioMapPkg::*;

    word_t                   segValue;              // Word shown on the display
    scanCnt_t                scanCnt;
    logic [DigitSelBits-1:0] digitSel;
    logic [3:0]              nibble;

    // Active low pattern {dp, g, f, e, d, c, b, a}, dot kept dark
    function automatic logic [7:0] hexToSeg(input logic [3:0] value);
        logic [7:0] pattern;
        case (value)
            4'h0: pattern = 8'hC0;
            4'h1: pattern = 8'hF9;
            4'h2: pattern = 8'hA4;
            4'h3: pattern = 8'hB0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hF8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'hA: pattern = 8'h88;
            4'hB: pattern = 8'h83;                  // Lower case b
            4'hC: pattern = 8'hC6;
            4'hD: pattern = 8'hA1;                  // Lower case d
            4'hE: pattern = 8'h86;
            default: pattern = 8'h8E;               // F
        endcase
        return pattern;
    endfunction

    // Store targets
    always_ff @(posedge clk) begin
        if (!rstN) begin
            led      <= '0;
            segValue <= '0;
        end else begin
            if (ledWe) begin
                led <= storeData[$bits(led_t)-1:0];  // Low half of the store
            end
            if (segWe) begin
                segValue <= storeData;
            end
        end
    end

    // Free running scan, top bits pick the digit
    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanCnt <= '0;
        end else begin
            scanCnt <= scanCnt + 1'b1;
        end
    end

    assign digitSel = scanCnt[ScanCntBits-1 -: DigitSelBits];
    assign nibble   = segValue[{digitSel, 2'b00} +: 4];

    always_comb begin
        seg.anode   = ~(SegDigits'(1) << digitSel);
        seg.cathode = hexToSeg(nibble);
    end

    // Lit digit moves one place at a time, so a single digit stays lit
    oneDigitLit: assert property (
        @(posedge clk) disable iff (!rstN)
        $changed(seg.anode) |->
            seg.anode == {$past(seg.anode[SegDigits-2:0]), $past(seg.anode[SegDigits-1])}
    ) else $error("displayPort: anode %b did not step by one digit", seg.anode);

endmodule

`default_nettype wire

//--- verilog/ioMapPkg.sv
`default_nettype none

package ioMapPkg;

    // IO window, matched on the upper 24 address bits
    localparam busPkg::word_t IoRegionBase = 32'hFFFF_FC00;
    localparam int            IoRegionLsb  = 8;

    localparam busPkg::word_t LedAddr    = 32'hFFFF_FC60;
    localparam busPkg::word_t SegAddr    = 32'hFFFF_FC64;
    localparam busPkg::word_t SwitchAddr = 32'hFFFF_FC70;
    localparam busPkg::word_t KeyAddr    = 32'hFFFF_FC74;
    localparam busPkg::word_t BtnAddr    = 32'hFFFF_FC78;

    typedef logic [11:0] switch_t;
    typedef logic [15:0] led_t;

    typedef struct packed {
        switch_t       switches;
        busPkg::word_t key;                         // Already decoded keypad code
        logic          btnRaw;                      // Asynchronous, bouncing
    } ioInputs_t;

    // Seven-segment display, eight digits
    localparam int SegDigits    = 8;
    localparam int DigitSelBits = $clog2(SegDigits);
    localparam int ScanDivBits  = 4;                // 16 clocks per digit
    localparam int ScanCntBits  = ScanDivBits + DigitSelBits;

    typedef logic [ScanCntBits-1:0] scanCnt_t;

    typedef struct packed {
        logic [SegDigits-1:0] anode;                // Active low, one digit at a time
        logic [7:0]           cathode;              // Active low, {dp, g..a}
    } segOut_t;

    // Button debounce
    localparam int DebounceCycles  = 16;
    localparam int DebounceCntBits = $clog2(DebounceCycles);

    typedef logic [DebounceCntBits-1:0] debCnt_t;

    localparam debCnt_t DebounceLimit = debCnt_t'(DebounceCycles - 1);

endpackage

`default_nettype wire

//--- verilog/ioSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module ioSubsystem (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire busPkg::memAccess_t access,
    input  wire ioMapPkg::ioInputs_t ioIn,
    output busPkg::word_t           rWdata,
    output ioMapPkg::led_t          led,
    output ioMapPkg::segOut_t       seg
);
    import busPkg::*;

    word_t     memRdata;
    logic      memWe;
    memIndex_t memIndex;
    word_t     storeData;
    logic      ledWe;
    logic      segWe;
    logic      btnLevel;

    // Access routing
    memOrIo memOrIo_inst (
        .access    (access),
        .memRdata  (memRdata),
        .switches  (ioIn.switches),
        .key       (ioIn.key),
        .btnLevel  (btnLevel),
        .rWdata    (rWdata),
        .memWe     (memWe),
        .memIndex  (memIndex),
        .storeData (storeData),
        .ledWe     (ledWe),
        .segWe     (segWe)
    );

    dataMem dataMem_inst (
        .clk   (clk),
        .rstN  (rstN),
        .we    (memWe),
        .index (memIndex),
        .wdata (storeData),
        .rdata (memRdata)
    );

    btnDebounce btnDebounce_inst (
        .clk      (clk),
        .rstN     (rstN),
        .btnRaw   (ioIn.btnRaw),
        .btnLevel (btnLevel)
    );

    // LEDs and seven-segment display
    displayPort displayPort_inst (
        .clk       (clk),
        .rstN      (rstN),
        .ledWe     (ledWe),
        .segWe     (segWe),
        .storeData (storeData),
        .led       (led),
        .seg       (seg)
    );

endmodule

`default_nettype wire

//--- verilog/memOrIo.sv
`timescale 1ns/1ps
`default_nettype none

module memOrIo (
    input  wire busPkg::memAccess_t access,
    input  wire busPkg::word_t      memRdata,       // Word read from dataMem
    input  wire ioMapPkg::switch_t  switches,
    input  wire busPkg::word_t      key,
    input  wire                     btnLevel,       // Debounced button
    output busPkg::word_t           rWdata,         // Register write-back data
    output logic                    memWe,
    output busPkg::memIndex_t       memIndex,
    output busPkg::word_t           storeData,      // Shared by memory and IO
    output logic                    ledWe,
    output logic                    segWe
);
    import busPkg::*;
    import ioMapPkg::*;

    logic inIoRegion;
    logic isSwitchAddr;
    logic isKeyAddr;
    logic isBtnAddr;
    logic isLedAddr;
    logic isSegAddr;
    logic isMemAddr;

    assign inIoRegion = (access.addr[31:IoRegionLsb] == IoRegionBase[31:IoRegionLsb]);

    // Exact peripheral matches
    assign isSwitchAddr = (access.addr == SwitchAddr);
    assign isKeyAddr    = (access.addr == KeyAddr);
    assign isBtnAddr    = (access.addr == BtnAddr);
    assign isLedAddr    = (access.addr == LedAddr);
    assign isSegAddr    = (access.addr == SegAddr);

    // Any other load goes to memory, even inside the IO window
    assign isMemAddr = !isSwitchAddr && !isKeyAddr && !isBtnAddr;

    assign memIndex = access.addr[MemIndexLsb +: MemIndexBits];

    // Load path, priority order matters
    always_comb begin
        if (access.read && isMemAddr)
            rWdata = memRdata;
        else if (access.read && isSwitchAddr)
            rWdata = word_t'(switches);             // Zero extended
        else if (access.read && isBtnAddr)
            rWdata = word_t'(btnLevel);
        else if (access.read && isKeyAddr)
            rWdata = key;
        else
            rWdata = access.addr;                   // No load, address passes through
    end

    // Store path
    assign memWe     = access.write && !inIoRegion;
    assign ledWe     = access.write && isLedAddr;
    assign segWe     = access.write && isSegAddr;
    assign storeData = access.write ? access.wdata : '0;

    // Decode invariants, checked once the comb logic has settled
    always_comb begin
        ledSegExclusive: assert #0 (!(ledWe && segWe))
            else $error("memOrIo: ledWe and segWe high together");
        // Every peripheral address must fall inside the IO window
        memWeOutsideIo: assert #0 (!(memWe && (isLedAddr || isSegAddr || isSwitchAddr ||
                                               isKeyAddr || isBtnAddr)))
            else $error("memOrIo: memory store to IO address %h", access.addr);
    end

endmodule

`default_nettype wire
